/* rtl/dmem_defines.svh */
`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// Byte address width seen by both masters.
`define DMEM_ADDR_WIDTH 16

// Data word width.
`define DMEM_DATA_WIDTH 32

// 1024 words, 4 KiB.
`define DMEM_DEPTH_LOG2 10

`endif

/* rtl/dmem_pkg.sv */
`include "dmem_defines.svh"

package dmem_pkg;

  typedef logic [`DMEM_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`DMEM_DATA_WIDTH-1:0]   data_t;
  typedef logic [`DMEM_DATA_WIDTH/8-1:0] be_t;  // One bit per byte.

  // Payload that goes with a req strobe.
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE, MEM_REQ, MEM_WAIT, RESP
  } axi_slave_state_t;

endpackage

/* rtl/ram_mux.sv */
`timescale 1ns/10ps

module ram_mux import dmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     port0_req_i,
  input  mem_req_t port0_req_data_i,
  output logic     port0_gnt_o,
  output logic     port0_rvalid_o,
  output data_t    port0_rdata_o,

  input  logic     port1_req_i,
  input  mem_req_t port1_req_data_i,
  output logic     port1_gnt_o,
  output logic     port1_rvalid_o,
  output data_t    port1_rdata_o,

  output logic     ram_en_o,
  output mem_req_t ram_req_o,
  input  data_t    ram_rdata_i
);

  always_comb
  begin
    port0_gnt_o = 1'b0;
    port1_gnt_o = 1'b0;
    if (port0_req_i)
    begin
      port0_gnt_o = 1'b1;  // Core always wins.
    end
    else if (port1_req_i)
    begin
      port1_gnt_o = 1'b1;
    end
  end

  assign ram_en_o  = port0_req_i | port1_req_i;
  assign ram_req_o = port0_req_i ? port0_req_data_i : port1_req_data_i;

  assign port0_rdata_o = ram_rdata_i;  // Broadcast, qualified by rvalid.
  assign port1_rdata_o = ram_rdata_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      port0_rvalid_o <= 1'b0;
      port1_rvalid_o <= 1'b0;
    end
    else
    begin
      port0_rvalid_o <= port0_gnt_o;
      port1_rvalid_o <= port1_gnt_o;
    end
  end

endmodule

/* rtl/dmem_sp_ram.sv */
`timescale 1ns/10ps
`include "dmem_defines.svh"

module dmem_sp_ram import dmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en_i,
  input  mem_req_t req_i,
  output data_t    rdata_o
);

  localparam int BYTES    = `DMEM_DATA_WIDTH / 8;
  localparam int BYTE_OFS = $clog2(BYTES);
  localparam int WORDS    = 1 << `DMEM_DEPTH_LOG2;

  data_t                      mem [WORDS];
  logic [`DMEM_DEPTH_LOG2-1:0] word_idx;

  assign word_idx = req_i.addr[BYTE_OFS +: `DMEM_DEPTH_LOG2];  // Upper bits wrap.

  always_ff @(posedge clk)
  begin
    if (en_i && req_i.we)
    begin
      for (int b = 0; b < BYTES; b++)
      begin
        if (req_i.be[b])
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      rdata_o <= '0;
    else if (en_i)
      rdata_o <= mem[word_idx];  // Old word on a write.
  end

endmodule

/* rtl/axi_lite_mem_slave.sv */
`timescale 1ns/10ps

module axi_lite_mem_slave import dmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     awvalid_i,
  output logic     awready_o,
  input  addr_t    awaddr_i,

  input  logic     wvalid_i,
  output logic     wready_o,
  input  data_t    wdata_i,
  input  be_t      wstrb_i,

  output logic     bvalid_o,
  input  logic     bready_i,

  input  logic     arvalid_i,
  output logic     arready_o,
  input  addr_t    araddr_i,

  output logic     rvalid_o,
  input  logic     rready_i,
  output data_t    rdata_o,

  output logic     mem_req_o,
  output mem_req_t mem_req_data_o,
  input  logic     mem_gnt_i,
  input  logic     mem_rvalid_i,
  input  data_t    mem_rdata_i
);

  axi_slave_state_t state_q;
  logic             aw_full_q;
  logic             w_full_q;
  logic             is_write_q;
  addr_t            aw_addr_q;
  data_t            w_data_q;
  be_t              w_strb_q;
  mem_req_t         req_q;
  data_t            rdata_q;

  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic wr_launch;

  assign awready_o = (state_q == IDLE) && !aw_full_q;
  assign wready_o  = (state_q == IDLE) && !w_full_q;
  assign arready_o = (state_q == IDLE) && !(aw_full_q && w_full_q);  // Full write wins.

  assign aw_hs     = awvalid_i && awready_o;
  assign w_hs      = wvalid_i && wready_o;
  assign ar_hs     = arvalid_i && arready_o;
  assign wr_launch = (state_q == IDLE) && aw_full_q && w_full_q;

  assign mem_req_o      = (state_q == MEM_REQ);
  assign mem_req_data_o = req_q;

  assign bvalid_o = (state_q == RESP) && is_write_q;
  assign rvalid_o = (state_q == RESP) && !is_write_q;
  assign rdata_o  = rdata_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q    <= IDLE;
      aw_full_q  <= 1'b0;
      w_full_q   <= 1'b0;
      is_write_q <= 1'b0;
    end
    else
    begin
      if (aw_hs)
        aw_full_q <= 1'b1;
      if (w_hs)
        w_full_q <= 1'b1;

      case (state_q)
        IDLE:
        begin
          if (wr_launch)
          begin
            aw_full_q  <= 1'b0;
            w_full_q   <= 1'b0;
            is_write_q <= 1'b1;
            state_q    <= MEM_REQ;
          end
          else if (ar_hs)
          begin
            is_write_q <= 1'b0;  // Write buffers, if any, wait for the next pass.
            state_q    <= MEM_REQ;
          end
        end
        MEM_REQ:
        begin
          if (mem_gnt_i)
            state_q <= MEM_WAIT;
        end
        MEM_WAIT:
        begin
          if (mem_rvalid_i)
            state_q <= RESP;
        end
        RESP:
        begin
          if (is_write_q ? bready_i : rready_i)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (aw_hs)
      aw_addr_q <= awaddr_i;
    if (w_hs)
    begin
      w_data_q <= wdata_i;
      w_strb_q <= wstrb_i;
    end
    if (wr_launch)
      req_q <= '{addr: aw_addr_q, we: 1'b1, be: w_strb_q, wdata: w_data_q};
    else if (ar_hs)
      req_q <= '{addr: araddr_i, we: 1'b0, be: '1, wdata: '0};  // Full word read.
    if (state_q == MEM_WAIT && mem_rvalid_i)
      rdata_q <= mem_rdata_i;
  end

endmodule

/* rtl/dmem_subsystem_top.sv */
`timescale 1ns/10ps

module dmem_subsystem_top import dmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     core_req_i,
  input  mem_req_t core_req_data_i,
  output logic     core_gnt_o,
  output logic     core_rvalid_o,
  output data_t    core_rdata_o,

  input  logic     s_axi_awvalid_i,
  output logic     s_axi_awready_o,
  input  addr_t    s_axi_awaddr_i,
  input  logic     s_axi_wvalid_i,
  output logic     s_axi_wready_o,
  input  data_t    s_axi_wdata_i,
  input  be_t      s_axi_wstrb_i,
  output logic     s_axi_bvalid_o,
  input  logic     s_axi_bready_i,
  input  logic     s_axi_arvalid_i,
  output logic     s_axi_arready_o,
  input  addr_t    s_axi_araddr_i,
  output logic     s_axi_rvalid_o,
  input  logic     s_axi_rready_i,
  output data_t    s_axi_rdata_o
);

  logic     axi_req;
  mem_req_t axi_req_data;
  logic     axi_gnt;
  logic     axi_rvalid;
  data_t    axi_rdata;

  logic     ram_en;
  mem_req_t ram_req;
  data_t    ram_rdata;

  axi_lite_mem_slave axi_slave_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .awvalid_i      (s_axi_awvalid_i),
    .awready_o      (s_axi_awready_o),
    .awaddr_i       (s_axi_awaddr_i),
    .wvalid_i       (s_axi_wvalid_i),
    .wready_o       (s_axi_wready_o),
    .wdata_i        (s_axi_wdata_i),
    .wstrb_i        (s_axi_wstrb_i),
    .bvalid_o       (s_axi_bvalid_o),
    .bready_i       (s_axi_bready_i),
    .arvalid_i      (s_axi_arvalid_i),
    .arready_o      (s_axi_arready_o),
    .araddr_i       (s_axi_araddr_i),
    .rvalid_o       (s_axi_rvalid_o),
    .rready_i       (s_axi_rready_i),
    .rdata_o        (s_axi_rdata_o),
    .mem_req_o      (axi_req),
    .mem_req_data_o (axi_req_data),
    .mem_gnt_i      (axi_gnt),
    .mem_rvalid_i   (axi_rvalid),
    .mem_rdata_i    (axi_rdata)
  );

  // Core on port 0 for priority.
  ram_mux ram_mux_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .port0_req_i      (core_req_i),
    .port0_req_data_i (core_req_data_i),
    .port0_gnt_o      (core_gnt_o),
    .port0_rvalid_o   (core_rvalid_o),
    .port0_rdata_o    (core_rdata_o),
    .port1_req_i      (axi_req),
    .port1_req_data_i (axi_req_data),
    .port1_gnt_o      (axi_gnt),
    .port1_rvalid_o   (axi_rvalid),
    .port1_rdata_o    (axi_rdata),
    .ram_en_o         (ram_en),
    .ram_req_o        (ram_req),
    .ram_rdata_i      (ram_rdata)
  );

  dmem_sp_ram ram_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (ram_en),
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

endmodule

/* verification/tb_dmem_subsystem.sv */
`timescale 1ns/10ps
`include "dmem_defines.svh"

module tb_dmem_subsystem import dmem_pkg::*;
();

  localparam int TIMEOUT = 100;

  logic clk, rst_n;
  logic core_req_i, core_gnt_o, core_rvalid_o;
  mem_req_t core_req_data_i;
  data_t core_rdata_o;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  data_t wdata, rdata;
  be_t wstrb;

  data_t model [1 << `DMEM_DEPTH_LOG2];
  integer seed;
  int errors, checks, tests;

  dmem_subsystem_top dut_i (
    .clk (clk), .rst_n (rst_n),
    .core_req_i (core_req_i), .core_req_data_i (core_req_data_i),
    .core_gnt_o (core_gnt_o), .core_rvalid_o (core_rvalid_o), .core_rdata_o (core_rdata_o),
    .s_axi_awvalid_i (awvalid), .s_axi_awready_o (awready), .s_axi_awaddr_i (awaddr),
    .s_axi_wvalid_i (wvalid), .s_axi_wready_o (wready), .s_axi_wdata_i (wdata),
    .s_axi_wstrb_i (wstrb), .s_axi_bvalid_o (bvalid), .s_axi_bready_i (bready),
    .s_axi_arvalid_i (arvalid), .s_axi_arready_o (arready), .s_axi_araddr_i (araddr),
    .s_axi_rvalid_o (rvalid), .s_axi_rready_i (rready), .s_axi_rdata_o (rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check(string name, data_t exp, data_t act);
    checks++;
    assert (act === exp) else
    begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    assert (act === exp) else
    begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout: %s never happened", what);
    $display("Verification failed");
    $finish;
  endtask

  // Byte-merge into the reference word.
  task automatic model_write(addr_t a, data_t d, be_t be);
    for (int b = 0; b < `DMEM_DATA_WIDTH / 8; b++)
    begin
      if (be[b])
        model[a[`DMEM_DEPTH_LOG2+1:2]][8*b +: 8] = d[8*b +: 8];
    end
  endtask

  task automatic core_access(string name, addr_t a, logic we, be_t be, data_t d);
    @(posedge clk);
    core_req_i <= 1'b1;
    core_req_data_i <= '{addr: a, we: we, be: be, wdata: d};
    @(negedge clk);
    check_bit({name, " gnt"}, 1'b1, core_gnt_o);
    @(posedge clk);
    core_req_i <= 1'b0;
    @(negedge clk);
    check_bit({name, " rvalid"}, 1'b1, core_rvalid_o);
    if (we)
      model_write(a, d, be);
    else
      check(name, model[a[`DMEM_DEPTH_LOG2+1:2]], core_rdata_o);
  endtask

  // Drops each valid once its handshake edge has passed.
  task automatic finish_write_valids();
    logic aw_ok, w_ok;
    int t;
    t = 0;
    @(negedge clk);
    while (awvalid || wvalid)
    begin
      t++;
      if (t == TIMEOUT)
        timeout_fail("AW or W handshake");
      aw_ok = awvalid && awready;
      w_ok  = wvalid && wready;
      @(posedge clk);
      if (aw_ok)
        awvalid <= 1'b0;
      if (w_ok)
        wvalid <= 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic finish_ar();
    int t;
    t = 0;
    @(negedge clk);
    while (!arready)
    begin
      t++;
      if (t == TIMEOUT)
        timeout_fail("AR handshake");
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
  endtask

  task automatic await_b(string name, int hold);
    int t;
    t = 0;
    @(negedge clk);
    while (!bvalid)
    begin
      t++;
      if (t == TIMEOUT)
        timeout_fail("write response");
      @(negedge clk);
    end
    repeat (hold)
    begin
      @(negedge clk);
      check_bit({name, " bvalid held"}, 1'b1, bvalid);
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
    @(negedge clk);
    check_bit({name, " single bvalid"}, 1'b0, bvalid);
  endtask

  task automatic await_r(string name, data_t exp, int hold);
    int t;
    t = 0;
    @(negedge clk);
    while (!rvalid)
    begin
      t++;
      if (t == TIMEOUT)
        timeout_fail("read response");
      @(negedge clk);
    end
    check(name, exp, rdata);
    repeat (hold)
    begin
      @(negedge clk);
      check_bit({name, " rvalid held"}, 1'b1, rvalid);
      check({name, " rdata held"}, exp, rdata);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
    @(negedge clk);
    check_bit({name, " single rvalid"}, 1'b0, rvalid);
  endtask

  task automatic axi_write(string name, addr_t a, data_t d, be_t be, logic aw_first, int hold);
    @(posedge clk);
    awaddr <= a;
    wdata  <= d;
    wstrb  <= be;
    if (aw_first)
      awvalid <= 1'b1;
    else
      wvalid <= 1'b1;
    finish_write_valids();
    @(posedge clk);
    if (aw_first)
      wvalid <= 1'b1;
    else
      awvalid <= 1'b1;
    finish_write_valids();
    await_b(name, hold);
    model_write(a, d, be);
  endtask

  task automatic axi_read(string name, addr_t a, int hold);
    @(posedge clk);
    araddr  <= a;
    arvalid <= 1'b1;
    finish_ar();
    await_r(name, model[a[`DMEM_DEPTH_LOG2+1:2]], hold);
  endtask

  task automatic report(string name, int errors_before);
    tests++;
    $display("test %s done, %0d errors", name, errors - errors_before);
  endtask

  task automatic core_port_test();
    int e0;
    e0 = errors;
    core_access("core_wr", 16'h0010, 1'b1, 4'hf, 32'h1122_3344);
    core_access("core_wr", 16'h0014, 1'b1, 4'hf, 32'h5566_7788);
    core_access("core_wr", 16'h0010, 1'b1, 4'b0101, 32'haabb_ccdd);
    core_access("core_wr", 16'h0014, 1'b1, 4'b1010, 32'heeff_0011);
    core_access("core_rd", 16'h0010, 1'b0, 4'hf, '0);
    core_access("core_rd", 16'h0014, 1'b0, 4'hf, '0);
    report("core_access", e0);
  endtask

  task automatic axi_port_test();
    int e0;
    e0 = errors;
    axi_write("axi_wr", 16'h0100, 32'hdead_beef, 4'hf, 1'b1, 0);
    axi_write("axi_wr", 16'h0104, 32'hcafe_f00d, 4'hf, 1'b0, 0);
    axi_write("axi_wr", 16'h0100, 32'h0102_0304, 4'b1100, 1'b0, 0);
    axi_write("axi_wr", 16'h0104, 32'h0506_0708, 4'b0011, 1'b1, 0);
    axi_read("axi_rd", 16'h0100, 0);
    axi_read("axi_rd", 16'h0104, 0);
    report("axi_access", e0);
  endtask

  task automatic shared_memory_test();
    int e0;
    e0 = errors;
    core_access("share_core_wr", 16'h0200, 1'b1, 4'hf, 32'h600d_cafe);
    axi_read("share_axi_rd", 16'h0200, 0);
    axi_write("share_axi_wr", 16'h0204, 32'h7777_aaaa, 4'hf, 1'b1, 0);
    core_access("share_core_rd", 16'h0204, 1'b0, 4'hf, '0);
    report("sharing", e0);
  endtask

  // Core keeps the mux busy while a read and a write wait in the slave.
  task automatic priority_test();
    int e0;
    e0 = errors;
    @(posedge clk);
    core_req_i <= 1'b1;
    core_req_data_i <= '{addr: 16'h0010, we: 1'b0, be: 4'hf, wdata: '0};
    awaddr <= 16'h0300;
    wdata <= 32'h1234_5678;
    wstrb <= 4'hf;
    araddr <= 16'h0104;
    awvalid <= 1'b1;
    wvalid <= 1'b1;
    arvalid <= 1'b1;
    @(negedge clk);
    check_bit("prio awready", 1'b1, awready);
    check_bit("prio wready", 1'b1, wready);
    check_bit("prio arready", 1'b1, arready);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    arvalid <= 1'b0;
    for (int i = 0; i < 20; i++)
    begin
      @(negedge clk);
      check_bit("prio core gnt", 1'b1, core_gnt_o);
      check_bit("prio no bvalid", 1'b0, bvalid);
      check_bit("prio no rvalid", 1'b0, rvalid);
    end
    @(posedge clk);
    core_req_i <= 1'b0;
    await_r("prio_rd", model[16'h0104 >> 2], 0);  // AR came with AW and W, so it goes first.
    await_b("prio_wr", 0);
    model_write(16'h0300, 32'h1234_5678, 4'hf);
    core_access("prio_core_rd", 16'h0300, 1'b0, 4'hf, '0);
    report("priority", e0);
  endtask

  task automatic backpressure_test();
    int e0;
    addr_t a;
    e0 = errors;
    for (int i = 0; i < 6; i++)
    begin
      a = addr_t'(16'h0400 + 4 * i);
      axi_write("bp_wr", a, data_t'($random(seed)), 4'hf, i[0], int'($unsigned($random(seed)) % 5));
      axi_read("bp_rd", a, int'($unsigned($random(seed)) % 5));
    end
    report("backpressure", e0);
  endtask

  task automatic random_mix_test();
    int e0;
    addr_t a;
    data_t d;
    be_t be;
    logic use_axi, we;
    e0 = errors;
    for (int w = 0; w < 32; w++)
      core_access("mix_fill", addr_t'(16'h0800 + 4 * w), 1'b1, 4'hf, data_t'($random(seed)));
    for (int i = 0; i < 60; i++)
    begin
      a = addr_t'($random(seed));  // Upper bits wrap onto the same word.
      a[`DMEM_DEPTH_LOG2+1:2] = 10'(10'h200 + ($unsigned($random(seed)) % 32));
      a[1:0] = 2'b00;
      d = data_t'($random(seed));
      be = be_t'($random(seed));
      use_axi = 1'($random(seed));
      we = 1'($random(seed));
      if (use_axi && we)
        axi_write("mix_axi_wr", a, d, be, 1'($random(seed)), 0);
      else if (use_axi)
        axi_read("mix_axi_rd", a, 0);
      else
        core_access(we ? "mix_core_wr" : "mix_core_rd", a, we, be, d);
    end
    report("random_mix", e0);
  endtask

  initial
  begin
    seed = 3053;
    errors = 0;
    checks = 0;
    tests = 0;
    rst_n = 1'b0;
    core_req_i = 1'b0;
    core_req_data_i = '0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    core_port_test();
    axi_port_test();
    shared_memory_test();
    priority_test();
    backpressure_test();
    random_mix_test();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* all.f */
+incdir+rtl
rtl/dmem_pkg.sv
rtl/ram_mux.sv
rtl/dmem_sp_ram.sv
rtl/axi_lite_mem_slave.sv
rtl/dmem_subsystem_top.sv
verification/tb_dmem_subsystem.sv

/* build.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_dmem_subsystem

out=$(./obj_dir/Vtb_dmem_subsystem)
echo "$out"

if grep -qx "Verification passed" <<< "$out"; then
  exit 0
else
  exit 1
fi
